/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := gpu_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard tb/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/gpu_pkg.sv */
package gpu_pkg;

    // Bus geometry of the register slave
    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    localparam int MAX_BLOCKS = 256;

    typedef logic [7:0]        block_id_t;
    typedef logic [7:0]        thread_cnt_t;
    typedef logic [8:0]        block_cnt_t;
    typedef logic [DATA_W-1:0] word_t;

    // num_blocks is one bit wider than a block id so that 256 fits
    typedef struct packed {
        block_cnt_t  num_blocks;
        thread_cnt_t threads_per_block;
        word_t       scale;
        word_t       bias;
    } kernel_config_t;

    typedef struct packed {
        block_id_t block_id;
        word_t     value;
    } core_result_t;

    // Register map
    localparam logic [ADDR_W-1:0] REG_CTRL       = 12'h000;
    localparam logic [ADDR_W-1:0] REG_STATUS     = 12'h004;
    localparam logic [ADDR_W-1:0] REG_NUM_BLOCKS = 12'h008;
    localparam logic [ADDR_W-1:0] REG_THREADS    = 12'h00C;
    localparam logic [ADDR_W-1:0] REG_SCALE      = 12'h010;
    localparam logic [ADDR_W-1:0] REG_BIAS       = 12'h014;
    localparam logic [ADDR_W-1:0] RESULT_BASE    = 12'h400;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        AXIL_IDLE,
        AXIL_WRESP,
        AXIL_RRESP
    } axil_state_e;

    typedef enum logic {
        DISP_IDLE,
        DISP_RUN
    } disp_state_e;

    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_COMPUTE,
        CORE_OFFER,
        CORE_FINISHED
    } core_state_e;

endpackage

/* core/block_core.sv */
`timescale 1ns/1ns

module block_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    core_reset,
    input  logic                    core_start,
    input  gpu_pkg::block_id_t      block_id,
    input  gpu_pkg::kernel_config_t kernel_config,

    // Result hand-off
    output logic                    result_valid,
    output gpu_pkg::core_result_t   result,
    input  logic                    result_ready,

    output logic                    core_done
);
    import gpu_pkg::*;

    core_state_e state;
    thread_cnt_t thread_idx;
    thread_cnt_t last_thread;
    block_id_t   block_q;
    word_t       gid_base;
    word_t       acc;
    word_t       thread_value;

    // Zero threads per block runs as a single thread
    assign last_thread = (kernel_config.threads_per_block == '0) ?
                         '0 : kernel_config.threads_per_block - 1'b1;

    // Global id times scale plus bias, wrapping at 32 bits
    assign thread_value = (gid_base + word_t'(thread_idx)) * kernel_config.scale
                          + kernel_config.bias;

    assign result_valid    = (state == CORE_OFFER);
    assign result.block_id = block_q;
    assign result.value    = acc;
    assign core_done       = (state == CORE_FINISHED);

    always_ff @(posedge clk) begin
        if (reset || core_reset) begin
            state <= CORE_IDLE;
        end else begin
            case (state)
                CORE_IDLE:     if (core_start) state <= CORE_COMPUTE;
                CORE_COMPUTE:  if (thread_idx == last_thread) state <= CORE_OFFER;
                CORE_OFFER:    if (result_ready) state <= CORE_FINISHED;
                CORE_FINISHED: state <= CORE_FINISHED;
                default:       state <= CORE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CORE_IDLE && core_start) begin
            block_q    <= block_id;
            gid_base   <= word_t'(block_id) * (word_t'(last_thread) + 1'b1);
            thread_idx <= '0;
            acc        <= '0;
        end else if (state == CORE_COMPUTE) begin
            acc        <= acc + thread_value;
            thread_idx <= thread_idx + 1'b1;
        end
    end

endmodule

/* dispatch/block_dispatcher.sv */
`timescale 1ns/1ns

module block_dispatcher #(
    parameter int NUM_CORES = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_pulse,
    input  gpu_pkg::kernel_config_t kernel_config,

    // Core handshake
    input  logic [NUM_CORES-1:0]    core_done,
    output logic [NUM_CORES-1:0]    core_start,
    output logic [NUM_CORES-1:0]    core_reset,
    output gpu_pkg::block_id_t      core_block_id [NUM_CORES],

    output logic                    kernel_done
);
    import gpu_pkg::*;

    disp_state_e          state;
    block_cnt_t           blocks_dispatched;
    block_cnt_t           blocks_done;
    block_cnt_t           next_dispatched;
    block_cnt_t           next_done;
    logic [NUM_CORES-1:0] launch;
    logic [NUM_CORES-1:0] finish;
    block_id_t            launch_id [NUM_CORES];

    // Several cores may pick up a block in the same cycle, in core order
    always_comb begin
        next_dispatched = blocks_dispatched;
        for (int i = 0; i < NUM_CORES; i++) begin
            launch[i]    = 1'b0;
            launch_id[i] = '0;
            if (core_reset[i] && next_dispatched < kernel_config.num_blocks) begin
                launch[i]       = 1'b1;
                launch_id[i]    = next_dispatched[7:0];
                next_dispatched = next_dispatched + 1'b1;
            end
        end
    end

    // Count every core that finishes this cycle
    always_comb begin
        finish    = core_start & core_done;
        next_done = blocks_done;
        for (int i = 0; i < NUM_CORES; i++) begin
            if (finish[i]) begin
                next_done = next_done + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state             <= DISP_IDLE;
            kernel_done       <= 1'b0;
            blocks_dispatched <= '0;
            blocks_done       <= '0;
            core_start        <= '0;
            core_reset        <= '1;
        end else begin
            case (state)
                DISP_IDLE: begin
                    if (start_pulse) begin
                        state             <= DISP_RUN;
                        kernel_done       <= 1'b0;
                        blocks_dispatched <= '0;
                        blocks_done       <= '0;
                        core_start        <= '0;
                        core_reset        <= '1;
                    end
                end
                DISP_RUN: begin
                    if (blocks_done == kernel_config.num_blocks) begin
                        kernel_done <= 1'b1;
                        state       <= DISP_IDLE;
                    end
                    blocks_dispatched <= next_dispatched;
                    blocks_done       <= next_done;
                    // A core leaves reset and takes a block on the same edge
                    core_reset <= finish;
                    core_start <= (core_start & ~finish) | launch;
                end
                default: state <= DISP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CORES; i++) begin
            if (state == DISP_RUN && launch[i]) begin
                core_block_id[i] <= launch_id[i];
            end
        end
    end

endmodule

/* sim.f */
+incdir+tb
common/gpu_pkg.sv
src/kernel_regs.sv
dispatch/block_dispatcher.sv
core/block_core.sv
src/result_store.sv
src/gpu_top.sv
tb/gpu_tb.sv

/* src/gpu_top.sv */
`timescale 1ns/1ns

module gpu_top #(
    parameter int NUM_CORES = 4
) (
    input  logic                       clk,
    input  logic                       reset,

    // AXI4-Lite slave
    input  logic [gpu_pkg::ADDR_W-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [gpu_pkg::DATA_W-1:0] wdata,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [gpu_pkg::ADDR_W-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [gpu_pkg::DATA_W-1:0] rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);
    import gpu_pkg::*;

    kernel_config_t       kernel_config;
    logic                 start_pulse;
    logic                 kernel_done;
    logic [NUM_CORES-1:0] core_done;
    logic [NUM_CORES-1:0] core_start;
    logic [NUM_CORES-1:0] core_reset;
    block_id_t            core_block_id [NUM_CORES];
    logic [NUM_CORES-1:0] result_valid;
    core_result_t         result [NUM_CORES];
    logic [NUM_CORES-1:0] result_ready;
    block_id_t            read_index;
    word_t                read_value;

    kernel_regs u_regs (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .kernel_config, .start_pulse, .kernel_done,
        .read_index, .read_value
    );

    block_dispatcher #(.NUM_CORES(NUM_CORES)) u_dispatcher (
        .clk, .reset, .start_pulse, .kernel_config,
        .core_done, .core_start, .core_reset, .core_block_id,
        .kernel_done
    );

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
        block_core u_core (
            .clk,
            .reset,
            .core_reset   (core_reset[i]),
            .core_start   (core_start[i]),
            .block_id     (core_block_id[i]),
            .kernel_config,
            .result_valid (result_valid[i]),
            .result       (result[i]),
            .result_ready (result_ready[i]),
            .core_done    (core_done[i])
        );
    end

    result_store #(.NUM_CORES(NUM_CORES)) u_store (
        .clk, .reset, .result_valid, .result, .result_ready,
        .read_index, .read_value
    );

endmodule

/* src/kernel_regs.sv */
`timescale 1ns/1ns

module kernel_regs (
    input  logic                        clk,
    input  logic                        reset,

    // AXI4-Lite slave
    input  logic [gpu_pkg::ADDR_W-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [gpu_pkg::DATA_W-1:0]  wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [gpu_pkg::ADDR_W-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [gpu_pkg::DATA_W-1:0]  rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,

    // Kernel control
    output gpu_pkg::kernel_config_t     kernel_config,
    output logic                        start_pulse,
    input  logic                        kernel_done,

    // Result window
    output gpu_pkg::block_id_t          read_index,
    input  gpu_pkg::word_t              read_value
);
    import gpu_pkg::*;

    axil_state_e    state;
    kernel_config_t cfg;
    logic           running;
    logic           wr_fire;
    logic           rd_fire;
    logic [1:0]     wr_resp;
    logic [1:0]     rd_resp;
    word_t          rd_word;

    // Address and data are taken in the same cycle, writes win over reads
    assign awready = (state == AXIL_IDLE) && awvalid && wvalid;
    assign wready  = awready;
    assign arready = (state == AXIL_IDLE) && arvalid && !(awvalid && wvalid);
    assign wr_fire = awready;
    assign rd_fire = arready;

    assign bvalid = (state == AXIL_WRESP);
    assign rvalid = (state == AXIL_RRESP);

    assign kernel_config = cfg;
    assign read_index    = araddr[9:2];

    always_comb begin
        case (awaddr)
            REG_CTRL, REG_STATUS, REG_NUM_BLOCKS,
            REG_THREADS, REG_SCALE, REG_BIAS: wr_resp = RESP_OKAY;
            default:                          wr_resp = RESP_SLVERR;
        endcase
    end

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        if (araddr[11:10] == RESULT_BASE[11:10]) begin
            // Only entries of the current kernel are readable
            if ({1'b0, read_index} < cfg.num_blocks) begin
                rd_word = read_value;
            end else begin
                rd_resp = RESP_SLVERR;
            end
        end else begin
            case (araddr)
                REG_CTRL:       rd_word = '0;
                REG_STATUS:     rd_word = {30'b0, running, kernel_done};
                REG_NUM_BLOCKS: rd_word = word_t'(cfg.num_blocks);
                REG_THREADS:    rd_word = word_t'(cfg.threads_per_block);
                REG_SCALE:      rd_word = cfg.scale;
                REG_BIAS:       rd_word = cfg.bias;
                default:        rd_resp = RESP_SLVERR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= AXIL_IDLE;
            start_pulse <= 1'b0;
            running     <= 1'b0;
            cfg         <= '0;
        end else begin
            start_pulse <= 1'b0;

            // Start wins over a done level left from the previous kernel
            if (start_pulse) begin
                running <= 1'b1;
            end else if (kernel_done) begin
                running <= 1'b0;
            end

            case (state)
                AXIL_IDLE: begin
                    if (wr_fire) begin
                        state <= AXIL_WRESP;
                        if (!running && !start_pulse) begin
                            case (awaddr)
                                REG_CTRL:       start_pulse <= wdata[0];
                                REG_NUM_BLOCKS: cfg.num_blocks <= (wdata > 32'd256) ?
                                                    9'd256 : wdata[8:0];
                                REG_THREADS:    cfg.threads_per_block <= wdata[7:0];
                                REG_SCALE:      cfg.scale <= wdata;
                                REG_BIAS:       cfg.bias <= wdata;
                                default:        ;
                            endcase
                        end
                    end else if (rd_fire) begin
                        state <= AXIL_RRESP;
                    end
                end
                AXIL_WRESP: if (bready) state <= AXIL_IDLE;
                AXIL_RRESP: if (rready) state <= AXIL_IDLE;
                default:    state <= AXIL_IDLE;
            endcase
        end
    end

    // Response payload, held stable while the response waits
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_resp;
        end
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

endmodule

/* src/result_store.sv */
`timescale 1ns/1ns

module result_store #(
    parameter int NUM_CORES = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [NUM_CORES-1:0]  result_valid,
    input  gpu_pkg::core_result_t result [NUM_CORES],
    output logic [NUM_CORES-1:0]  result_ready,
    input  gpu_pkg::block_id_t    read_index,
    output gpu_pkg::word_t        read_value
);
    import gpu_pkg::*;

    localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

    word_t          mem [MAX_BLOCKS];
    logic [IDX_W-1:0] last_grant;
    logic [IDX_W-1:0] grant_idx;
    logic             grant_any;

    // Search starts at the core after the last one served
    always_comb begin
        int unsigned cand;
        grant_any    = 1'b0;
        grant_idx    = last_grant;
        result_ready = '0;
        for (int k = 1; k <= NUM_CORES; k++) begin
            cand = (int'(last_grant) + k) % NUM_CORES;
            if (!grant_any && result_valid[cand]) begin
                grant_any = 1'b1;
                grant_idx = IDX_W'(cand);
            end
        end
        if (grant_any) begin
            result_ready[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= IDX_W'(NUM_CORES - 1);
        end else if (grant_any) begin
            last_grant <= grant_idx;
        end
    end

    // One result per cycle at most
    always_ff @(posedge clk) begin
        if (grant_any) begin
            mem[result[grant_idx].block_id] <= result[grant_idx].value;
        end
    end

    assign read_value = mem[read_index];

endmodule

/* tb/axil_tasks.svh */
`ifndef AXIL_TASKS_SVH
`define AXIL_TASKS_SVH

// Random hold-off before the master accepts a response
function automatic int response_delay();
    if (resp_delay_max == 0) begin
        return 0;
    end
    return int'($urandom_range(resp_delay_max, 0));
endfunction

// Both tasks start 1 ns after a rising edge and return at the same phase
task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    int delay;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) begin
        @(negedge clk);
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    delay   = response_delay();
    repeat (delay) begin
        @(posedge clk);
        #1;
    end
    bready = 1'b1;
    @(negedge clk);
    while (!bvalid) begin
        @(negedge clk);
    end
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
endtask

task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    int delay;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) begin
        @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    delay   = response_delay();
    repeat (delay) begin
        @(posedge clk);
        #1;
    end
    rready = 1'b1;
    @(negedge clk);
    while (!rvalid) begin
        @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
endtask

`endif

/* tb/gpu_tb.sv */
`timescale 1ns/1ns

module gpu_tb;
    import gpu_pkg::*;

    localparam int NUM_CORES = 4;
    // 256 blocks of 256 threads over 4 cores is about 16.4k cycles, plus bus traffic
    localparam int WATCHDOG_NS = 200000;

    logic        clk;
    logic        reset;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    int          resp_delay_max;

    // Pending comparisons, drained by the compare process
    string       name_q [$];
    logic [31:0] got_q [$];
    logic [31:0] exp_q [$];

    `include "axil_tasks.svh"

    gpu_top #(.NUM_CORES(NUM_CORES)) dut (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
    );

    always #5 clk = ~clk;

    // Sum over the block's threads of global id * scale + bias, wrapping at 32 bits
    function automatic logic [31:0] expected_result(input int block, input int threads,
                                                    input logic [31:0] scale,
                                                    input logic [31:0] bias);
        logic [31:0] sum;
        logic [31:0] gid;
        int          count;
        count = (threads == 0) ? 1 : threads;
        sum   = '0;
        for (int t = 0; t < count; t++) begin
            gid = 32'(block * count + t);
            sum = sum + gid * scale + bias;
        end
        return sum;
    endfunction

    function automatic void expect_word(input string name, input logic [31:0] got,
                                        input logic [31:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    always @(posedge clk) begin
        while (got_q.size() > 0) begin
            check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
        end
    end

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        expect_word($sformatf("bresp@%03h", addr), 32'(resp), 32'(RESP_OKAY));
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        axil_read(addr, data, resp);
        expect_word($sformatf("rresp@%03h", addr), 32'(resp), 32'(RESP_OKAY));
    endtask

    task automatic configure(input logic [31:0] blocks, input logic [31:0] threads,
                             input logic [31:0] scale, input logic [31:0] bias);
        write_reg(REG_NUM_BLOCKS, blocks);
        write_reg(REG_THREADS, threads);
        write_reg(REG_SCALE, scale);
        write_reg(REG_BIAS, bias);
    endtask

    // Poll STATUS; until done rises the kernel must show busy
    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        while (!status[0]) begin
            read_reg(REG_STATUS, status);
            if (!status[0]) begin
                expect_word("STATUS.busy", 32'(status[1]), 32'd1);
            end
        end
        read_reg(REG_STATUS, status);
        expect_word("STATUS after done", status, 32'd1);
    endtask

    task automatic check_results(input int blocks, input int threads,
                                 input logic [31:0] scale, input logic [31:0] bias);
        logic [31:0] data;
        for (int i = 0; i < blocks; i++) begin
            read_reg(RESULT_BASE + 12'(4 * i), data);
            expect_word($sformatf("RESULT[%0d]", i), data,
                        expected_result(i, threads, scale, bias));
        end
    endtask

    task automatic run_kernel(input int blocks, input int threads,
                              input logic [31:0] scale, input logic [31:0] bias);
        configure(32'(blocks), 32'(threads), scale, bias);
        write_reg(REG_CTRL, 32'd1);
        wait_done();
        check_results(blocks, threads, scale, bias);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the kernels did not finish within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        int          nb;
        int          th;
        clk            = 1'b0;
        reset          = 1'b1;
        awaddr         = '0;
        awvalid        = 1'b0;
        wdata          = '0;
        wvalid         = 1'b0;
        bready         = 1'b0;
        araddr         = '0;
        arvalid        = 1'b0;
        rready         = 1'b0;
        resp_delay_max = 0;
        void'($urandom(81));
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Register access and unmapped addresses
        read_reg(REG_STATUS, data);
        expect_word("STATUS after reset", data, 32'd0);
        configure(32'd5, 32'd9, 32'h1234_5678, 32'hdead_beef);
        read_reg(REG_NUM_BLOCKS, data);
        expect_word("NUM_BLOCKS", data, 32'd5);
        read_reg(REG_THREADS, data);
        expect_word("THREADS", data, 32'd9);
        read_reg(REG_SCALE, data);
        expect_word("SCALE", data, 32'h1234_5678);
        read_reg(REG_BIAS, data);
        expect_word("BIAS", data, 32'hdead_beef);
        axil_write(12'h018, 32'd1, resp);
        expect_word("bresp unmapped", 32'(resp), 32'(RESP_SLVERR));
        axil_read(12'h018, data, resp);
        expect_word("rresp unmapped", 32'(resp), 32'(RESP_SLVERR));

        run_kernel(3, 5, 32'd7, 32'd11);

        // More blocks than cores, config frozen while busy
        configure(32'd12, 32'd20, 32'd3, 32'd7);
        write_reg(REG_CTRL, 32'd1);
        read_reg(REG_STATUS, data);
        expect_word("STATUS while busy", data, 32'd2);
        write_reg(REG_SCALE, 32'd99);
        read_reg(REG_SCALE, data);
        expect_word("SCALE while busy", data, 32'd3);
        axil_read(RESULT_BASE + 12'(4 * 12), data, resp);
        expect_word("rresp RESULT[12]", 32'(resp), 32'(RESP_SLVERR));
        wait_done();
        check_results(12, 20, 32'd3, 32'd7);

        // Random kernels under response back-pressure
        resp_delay_max = 3;
        for (int run = 0; run < 6; run++) begin
            nb = int'($urandom_range(40, 1));
            th = int'($urandom_range(20, 0));
            run_kernel(nb, th, $urandom, $urandom);
        end
        resp_delay_max = 0;

        // Zero blocks, then a restart after done
        configure(32'd0, 32'd3, 32'd1, 32'd1);
        write_reg(REG_CTRL, 32'd1);
        wait_done();
        axil_read(RESULT_BASE, data, resp);
        expect_word("rresp RESULT[0] empty", 32'(resp), 32'(RESP_SLVERR));
        configure(32'd2, 32'd4, 32'd5, 32'd6);
        write_reg(REG_CTRL, 32'd1);
        read_reg(REG_STATUS, data);
        expect_word("STATUS after restart", data, 32'd2);
        wait_done();
        check_results(2, 4, 32'd5, 32'd6);

        repeat (2) @(posedge clk);
        if (got_q.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Comparisons were left unchecked at the end of the run");
            $display("Finished with errors");
            $fatal(1, "Compare queue not empty");
        end
    end

endmodule
